//--- Bender.yml
package:
  name: copad_finder

sources:
  - include_dirs:
      - source
    files:
      - source/gem_geometry_pkg.sv
      - source/copad_match_pkg.sv
      - source/cluster_if.sv
      - source/cluster_capture.sv
      - source/pad_window_matcher.sv
      - source/match_collector.sv
      - source/copad_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - testbench/copad_tb.sv

//--- compile.f
+incdir+source
source/gem_geometry_pkg.sv
source/copad_match_pkg.sv
source/cluster_if.sv
source/cluster_capture.sv
source/pad_window_matcher.sv
source/match_collector.sv
source/copad_top.sv
testbench/copad_tb.sv

//--- source/cluster_capture.sv
// cluster capture: registers both chambers' clusters and the match config
`timescale 1ns/100ps
`include "copad_settings.svh"

module cluster_capture (
    input  logic                                            clock,
    input  logic                                            arst_n,
    input  logic [`COPAD_N_CLUSTERS-1:0]                    a_vpf,
    input  gem_geometry_pkg::roll_t [`COPAD_N_CLUSTERS-1:0] a_roll,
    input  gem_geometry_pkg::pad_t [`COPAD_N_CLUSTERS-1:0]  a_pad,
    input  gem_geometry_pkg::cnt_t [`COPAD_N_CLUSTERS-1:0]  a_cnt,
    input  logic [`COPAD_N_CLUSTERS-1:0]                    b_vpf,
    input  gem_geometry_pkg::roll_t [`COPAD_N_CLUSTERS-1:0] b_roll,
    input  gem_geometry_pkg::pad_t [`COPAD_N_CLUSTERS-1:0]  b_pad,
    input  gem_geometry_pkg::cnt_t [`COPAD_N_CLUSTERS-1:0]  b_cnt,
    input  logic                                            match_neighbor_roll,
    input  logic                                            match_neighbor_pad,
    input  gem_geometry_pkg::delta_t                        match_delta_pad,
    cluster_if.driver                                       a_bus,
    cluster_if.driver                                       b_bus,
    output gem_geometry_pkg::delta_t                        pad_delta,
    output logic                                            roll_neighbor
);

    // ------------------------------
    // one crossing per clock
    // ------------------------------

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            a_bus.vpf     <= '0;
            a_bus.roll    <= '0;
            a_bus.pad     <= '0;
            a_bus.cnt     <= '0;
            b_bus.vpf     <= '0;
            b_bus.roll    <= '0;
            b_bus.pad     <= '0;
            b_bus.cnt     <= '0;
            pad_delta     <= '0;
            roll_neighbor <= 1'b0;
        end else begin
            a_bus.vpf     <= a_vpf;
            a_bus.roll    <= a_roll;
            a_bus.pad     <= a_pad;
            a_bus.cnt     <= a_cnt;
            b_bus.vpf     <= b_vpf;
            b_bus.roll    <= b_roll;
            b_bus.pad     <= b_pad;
            b_bus.cnt     <= b_cnt;
            // tolerance collapses to an exact match when the pad switch is off
            pad_delta     <= match_neighbor_pad ? match_delta_pad : '0;
            roll_neighbor <= match_neighbor_roll;  // stays aligned with its crossing
        end
    end

    // valid clusters must sit inside the roll, the matchers rely on it
    for (genvar i = 0; i < `COPAD_N_CLUSTERS; i++) begin : g_pad_range
        a_pad_in_roll : assert property (@(posedge clock) disable iff (!arst_n)
            a_bus.vpf[i] |-> a_bus.pad[i] <= `COPAD_LAST_PAD);
        b_pad_in_roll : assert property (@(posedge clock) disable iff (!arst_n)
            b_bus.vpf[i] |-> b_bus.pad[i] <= `COPAD_LAST_PAD);
    end

endmodule

//--- source/cluster_if.sv
// cluster bus: one chamber's registered clusters for a bunch crossing
`timescale 1ns/100ps
`include "copad_settings.svh"

interface cluster_if;

    // ------------------------------
    // cluster fields, refreshed every clock
    // ------------------------------

    logic [`COPAD_N_CLUSTERS-1:0]                        vpf;   // cluster valid
    gem_geometry_pkg::roll_t [`COPAD_N_CLUSTERS-1:0]     roll;
    gem_geometry_pkg::pad_t [`COPAD_N_CLUSTERS-1:0]      pad;   // starting pad
    gem_geometry_pkg::cnt_t [`COPAD_N_CLUSTERS-1:0]      cnt;

    // capture stage side
    modport driver (
        output vpf,
        output roll,
        output pad,
        output cnt
    );

    // matcher side
    modport receiver (
        input vpf,
        input roll,
        input pad,
        input cnt
    );

endinterface

//--- source/copad_match_pkg.sv
// co-pad match package: per-cluster result vector types
`include "copad_settings.svh"

package copad_match_pkg;

    // one bit per chamber A cluster
    typedef logic [`COPAD_N_CLUSTERS-1:0] match_vec_t;

    // one bit per chamber B cluster, used inside a matcher
    typedef logic [`COPAD_N_CLUSTERS-1:0] b_hit_vec_t;

endpackage

//--- source/copad_settings.svh
// co-pad finder settings: cluster counts, pad range and field widths
`ifndef COPAD_SETTINGS_SVH
`define COPAD_SETTINGS_SVH

// ------------------------------
// chamber geometry
// ------------------------------

`define COPAD_N_CLUSTERS 8    // clusters per chamber per crossing
`define COPAD_N_ROLLS    8    // eta partitions
`define COPAD_LAST_PAD   191  // highest pad in a roll

// ------------------------------
// field widths
// ------------------------------

`define COPAD_PAD_BITS   8
`define COPAD_ROLL_BITS  3
`define COPAD_CNT_BITS   3    // additional pads, 0..7
`define COPAD_DELTA_BITS 4    // pad tolerance, 0..15

`endif

//--- source/copad_top.sv
// co-pad finder top: capture, eight window matchers and the result collector
`timescale 1ns/100ps
`include "copad_settings.svh"

module copad_top (
    input  logic                                            clock,
    input  logic                                            arst_n,
    input  logic [`COPAD_N_CLUSTERS-1:0]                    a_vpf,
    input  gem_geometry_pkg::roll_t [`COPAD_N_CLUSTERS-1:0] a_roll,
    input  gem_geometry_pkg::pad_t [`COPAD_N_CLUSTERS-1:0]  a_pad,
    input  gem_geometry_pkg::cnt_t [`COPAD_N_CLUSTERS-1:0]  a_cnt,
    input  logic [`COPAD_N_CLUSTERS-1:0]                    b_vpf,
    input  gem_geometry_pkg::roll_t [`COPAD_N_CLUSTERS-1:0] b_roll,
    input  gem_geometry_pkg::pad_t [`COPAD_N_CLUSTERS-1:0]  b_pad,
    input  gem_geometry_pkg::cnt_t [`COPAD_N_CLUSTERS-1:0]  b_cnt,
    input  logic                                            match_neighbor_roll,
    input  logic                                            match_neighbor_pad,
    input  gem_geometry_pkg::delta_t                        match_delta_pad,
    output copad_match_pkg::match_vec_t                     match,
    output copad_match_pkg::match_vec_t                     match_upper,
    output copad_match_pkg::match_vec_t                     match_lower,
    output logic                                            any_match
);

    gem_geometry_pkg::delta_t    pad_delta;
    logic                        roll_neighbor;
    copad_match_pkg::match_vec_t same_vec;
    copad_match_pkg::match_vec_t upper_vec;
    copad_match_pkg::match_vec_t lower_vec;

    cluster_if a_bus ();  // chamber A
    cluster_if b_bus ();  // chamber B

    // ------------------------------
    // stage 1: input registers
    // ------------------------------

    cluster_capture i_cluster_capture (
        .clock               (clock),
        .arst_n              (arst_n),
        .a_vpf               (a_vpf),
        .a_roll              (a_roll),
        .a_pad               (a_pad),
        .a_cnt               (a_cnt),
        .b_vpf               (b_vpf),
        .b_roll              (b_roll),
        .b_pad               (b_pad),
        .b_cnt               (b_cnt),
        .match_neighbor_roll (match_neighbor_roll),
        .match_neighbor_pad  (match_neighbor_pad),
        .match_delta_pad     (match_delta_pad),
        .a_bus               (a_bus),
        .b_bus               (b_bus),
        .pad_delta           (pad_delta),
        .roll_neighbor       (roll_neighbor)
    );

    // one matcher per A cluster
    for (genvar i = 0; i < `COPAD_N_CLUSTERS; i++) begin : g_matcher
        pad_window_matcher #(
            .cluster_index (i)
        ) i_pad_window_matcher (
            .clock     (clock),
            .arst_n    (arst_n),
            .a_bus     (a_bus),
            .b_bus     (b_bus),
            .pad_delta (pad_delta),
            .same_hit  (same_vec[i]),
            .upper_hit (upper_vec[i]),
            .lower_hit (lower_vec[i])
        );
    end

    // ------------------------------
    // stage 2: output registers
    // ------------------------------

    match_collector i_match_collector (
        .clock         (clock),
        .arst_n        (arst_n),
        .same_vec      (same_vec),
        .upper_vec     (upper_vec),
        .lower_vec     (lower_vec),
        .roll_neighbor (roll_neighbor),
        .match         (match),
        .match_upper   (match_upper),
        .match_lower   (match_lower),
        .any_match     (any_match)
    );

endmodule

//--- source/gem_geometry_pkg.sv
// gem geometry package: roll, pad, cluster size and tolerance types
`include "copad_settings.svh"

package gem_geometry_pkg;

    // roll (eta partition) number
    typedef logic [`COPAD_ROLL_BITS-1:0] roll_t;

    // starting pad of a cluster
    typedef logic [`COPAD_PAD_BITS-1:0] pad_t;

    typedef logic [`COPAD_CNT_BITS-1:0] cnt_t;      // pads beyond the first
    typedef logic [`COPAD_DELTA_BITS-1:0] delta_t;  // match tolerance in pads

    // window bounds carry one spare bit so sums never wrap
    typedef logic [`COPAD_PAD_BITS:0] wide_pad_t;

endpackage

//--- source/match_collector.sv
// match collector: neighbor-roll gating and registered match outputs
`timescale 1ns/100ps
`include "copad_settings.svh"

module match_collector (
    input  logic                        clock,
    input  logic                        arst_n,
    input  copad_match_pkg::match_vec_t same_vec,
    input  copad_match_pkg::match_vec_t upper_vec,
    input  copad_match_pkg::match_vec_t lower_vec,
    input  logic                        roll_neighbor,
    output copad_match_pkg::match_vec_t match,
    output copad_match_pkg::match_vec_t match_upper,
    output copad_match_pkg::match_vec_t match_lower,
    output logic                        any_match
);

    copad_match_pkg::match_vec_t match_full;

    // ------------------------------
    // combine same and neighbor rolls
    // ------------------------------

    assign match_full = same_vec
                      | ({`COPAD_N_CLUSTERS{roll_neighbor}} & (upper_vec | lower_vec));

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            match       <= '0;
            match_upper <= '0;
            match_lower <= '0;
            any_match   <= 1'b0;
        end else begin
            match       <= match_full;
            match_upper <= upper_vec;  // raw, not gated by the roll switch
            match_lower <= lower_vec;
            any_match   <= |match_full;
        end
    end

endmodule

//--- source/pad_window_matcher.sv
// pad window matcher: one A cluster's window against all B clusters
`timescale 1ns/100ps
`include "copad_settings.svh"

module pad_window_matcher #(
    parameter int cluster_index = 0  // which A cluster, 0..7
) (
    input  logic                     clock,
    input  logic                     arst_n,
    cluster_if.receiver              a_bus,
    cluster_if.receiver              b_bus,
    input  gem_geometry_pkg::delta_t pad_delta,
    output logic                     same_hit,
    output logic                     upper_hit,
    output logic                     lower_hit
);

    logic                        a_vpf;
    gem_geometry_pkg::roll_t     a_roll;
    gem_geometry_pkg::pad_t      a_pad;
    gem_geometry_pkg::cnt_t      a_cnt;
    gem_geometry_pkg::wide_pad_t lo;
    gem_geometry_pkg::wide_pad_t hi;
    gem_geometry_pkg::wide_pad_t hi_sum;   // unclamped upper bound
    copad_match_pkg::b_hit_vec_t pad_overlap;
    copad_match_pkg::b_hit_vec_t same_roll;
    copad_match_pkg::b_hit_vec_t upper_roll;
    copad_match_pkg::b_hit_vec_t lower_roll;

    assign a_vpf  = a_bus.vpf[cluster_index];
    assign a_roll = a_bus.roll[cluster_index];
    assign a_pad  = a_bus.pad[cluster_index];
    assign a_cnt  = a_bus.cnt[cluster_index];

    // ------------------------------
    // clamped pad window
    // ------------------------------

    assign hi_sum = gem_geometry_pkg::wide_pad_t'(a_pad)
                  + gem_geometry_pkg::wide_pad_t'(a_cnt)
                  + gem_geometry_pkg::wide_pad_t'(pad_delta);

    assign lo = (a_pad < pad_delta) ? '0     // floor at pad 0
              : gem_geometry_pkg::wide_pad_t'(a_pad) - gem_geometry_pkg::wide_pad_t'(pad_delta);
    assign hi = (hi_sum > `COPAD_LAST_PAD) ? gem_geometry_pkg::wide_pad_t'(`COPAD_LAST_PAD)
              : hi_sum;

    // ------------------------------
    // compare against every B cluster
    // ------------------------------

    always_comb begin
        gem_geometry_pkg::wide_pad_t b_first;
        gem_geometry_pkg::wide_pad_t b_last;
        for (int j = 0; j < `COPAD_N_CLUSTERS; j++) begin
            b_first = gem_geometry_pkg::wide_pad_t'(b_bus.pad[j]);
            b_last  = b_first + gem_geometry_pkg::wide_pad_t'(b_bus.cnt[j]);
            // either end of the B cluster inside lo..hi
            pad_overlap[j] = b_bus.vpf[j]
                           & (((b_first >= lo) & (b_first <= hi))
                           | ((b_last >= lo) & (b_last <= hi)));
            same_roll[j]  = (b_bus.roll[j] == a_roll);
            upper_roll[j] = (a_roll != '0)
                          & (b_bus.roll[j] == gem_geometry_pkg::roll_t'(a_roll - 1'b1));
            lower_roll[j] = (a_roll != gem_geometry_pkg::roll_t'(`COPAD_N_ROLLS - 1))
                          & (b_bus.roll[j] == gem_geometry_pkg::roll_t'(a_roll + 1'b1));
        end
    end

    // reduce by roll relation, gated by the A cluster's valid
    assign same_hit  = a_vpf & (|(pad_overlap & same_roll));
    assign upper_hit = a_vpf & (|(pad_overlap & upper_roll));
    assign lower_hit = a_vpf & (|(pad_overlap & lower_roll));

    // holds only while the capture stage delivers pads within the roll
    window_ordered : assert property (@(posedge clock) disable iff (!arst_n)
        a_vpf |-> lo <= hi);

endmodule

//--- testbench/copad_golden.txt
// columns: config r_p_d (roll switch, pad switch, delta), a0..a7, b0..b7, expected mm_uu_ll_a
// cluster word v_r_pp_c is valid, roll, start pad, extra pads; expected is match, upper, lower, any
0_0_0 1_2_28_1 0 0 0 0 0 0 0 1_2_29_0 0 0 0 0 0 0 0 01_00_00_1
0_0_0 1_2_28_1 0 0 0 0 0 0 0 1_2_2a_0 1_2_26_1 0 0 0 0 0 0 00_00_00_0
0_0_5 1_2_28_1 0 0 1_5_64_0 0 0 0 0 1_2_2a_0 0 0 0 0 1_5_60_4 0 0 08_00_00_1
0_0_0 0 1_4_64_0 1_4_62_4 0 0 0 0 0 0 0 1_4_62_4 0 0 0 0 0 04_00_00_1
0_1_3 1_1_50_2 1_3_50_2 0 0 0 0 0 0 1_1_55_0 1_3_56_0 1_3_48_4 0 0 0 0 0 01_00_00_1
0_1_3 1_1_50_2 1_3_50_2 1_5_50_2 0 0 0 0 0 1_1_4a_3 1_3_4d_0 1_5_4c_0 0 0 0 0 0 03_00_00_1
0_1_3 1_0_01_0 1_2_01_0 1_4_02_1 0 0 0 0 0 1_0_00_0 1_2_05_0 1_4_06_0 0 0 0 0 0 05_00_00_1
0_1_3 1_6_bd_2 1_0_bf_7 1_2_b8_0 1_4_bd_2 0 0 0 0 1_6_bf_0 1_0_bc_0 1_2_bc_3 1_4_b9_7 0 0 0 0 03_00_00_1
0_1_f 1_3_64_0 1_5_64_0 1_7_0a_0 0 0 0 0 0 1_3_55_0 1_5_74_0 1_7_19_0 0 0 0 0 0 05_00_00_1
0_0_0 1_3_20_0 1_5_40_0 0 0 0 0 0 0 1_2_20_0 1_6_40_0 0 0 0 0 0 0 00_01_02_0
1_0_0 1_3_20_0 1_5_40_0 0 0 0 0 0 0 1_2_20_0 1_6_40_0 0 0 0 0 0 0 03_01_02_1
1_0_0 1_0_30_0 1_7_50_0 1_0_70_0 1_7_90_0 0 0 0 0 1_7_30_0 1_0_50_0 1_1_70_0 1_6_90_0 0 0 0 0 0c_08_04_1
0_0_0 0 0 0 0 1_4_80_2 0 0 0 0 0 0 0 1_4_82_0 1_3_7e_2 1_5_81_0 0 10_10_10_1
1_1_2 0 0 0 0 0 0 1_2_10_1 1_6_a0_0 0 0 0 0 0 1_5_9e_0 1_7_a3_0 1_1_0c_2 c0_c0_00_1
1_1_3 1_2_40_1 0 0 0 0 0 0 0 0_2_40_1 0_3_41_0 0 0 0 0 0 0 00_00_00_0
1_1_3 0_2_40_1 1_5_40_0 0 0 0 0 0 0 1_2_40_0 1_1_40_0 1_3_40_0 0 0 0 0 0 00_00_00_0
1_0_0 1_0_20_0 1_1_20_0 1_2_20_0 1_3_20_0 1_4_20_0 0 0 0 1_3_20_0 0_2_20_0 0 0 0 0 0 0 1c_10_04_1
0_0_0 1_3_50_0 0 0 0 0 0 0 0 1_3_53_0 1_4_50_0 0 0 0 0 0 0 00_00_01_0
0_1_3 1_3_50_0 0 0 0 0 0 0 0 1_3_53_0 1_4_50_0 0 0 0 0 0 0 01_00_01_1
1_0_0 1_3_50_0 0 0 0 0 0 0 0 1_3_53_0 1_4_50_0 0 0 0 0 0 0 01_00_01_1
0_1_2 1_3_50_0 0 0 0 0 0 0 0 1_3_53_0 1_4_50_0 0 0 0 0 0 0 00_00_01_0
1_1_3 1_3_50_0 0 0 0 0 0 0 0 1_3_53_0 1_4_50_0 0 0 0 0 0 0 01_00_01_1
0_0_3 1_3_50_0 0 0 0 0 0 0 0 1_3_53_0 1_4_50_0 0 0 0 0 0 0 00_00_01_0
0_0_0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 00_00_00_0

//--- testbench/copad_tb.sv
// co-pad finder testbench: drives golden crossings and checks the registered match outputs
`timescale 1ns/100ps
`include "copad_settings.svh"

module copad_tb;

    localparam int n_vectors      = 24;
    localparam int words_per_line = 2 * `COPAD_N_CLUSTERS + 2;  // config, A, B, expected
    localparam int latency        = 2;
    localparam int timeout_cycles = n_vectors + 50;
    localparam     golden_file    = "testbench/copad_golden.txt";

    logic                                            clock;
    logic                                            arst_n;
    logic [`COPAD_N_CLUSTERS-1:0]                    a_vpf;
    gem_geometry_pkg::roll_t [`COPAD_N_CLUSTERS-1:0] a_roll;
    gem_geometry_pkg::pad_t [`COPAD_N_CLUSTERS-1:0]  a_pad;
    gem_geometry_pkg::cnt_t [`COPAD_N_CLUSTERS-1:0]  a_cnt;
    logic [`COPAD_N_CLUSTERS-1:0]                    b_vpf;
    gem_geometry_pkg::roll_t [`COPAD_N_CLUSTERS-1:0] b_roll;
    gem_geometry_pkg::pad_t [`COPAD_N_CLUSTERS-1:0]  b_pad;
    gem_geometry_pkg::cnt_t [`COPAD_N_CLUSTERS-1:0]  b_cnt;
    logic                                            match_neighbor_roll;
    logic                                            match_neighbor_pad;
    gem_geometry_pkg::delta_t                        match_delta_pad;
    copad_match_pkg::match_vec_t                     match;
    copad_match_pkg::match_vec_t                     match_upper;
    copad_match_pkg::match_vec_t                     match_lower;
    logic                                            any_match;

    logic [27:0] golden [0:n_vectors*words_per_line-1];
    int          sent[$];   // vector index per driven crossing, -1 when idle
    int          errors;
    int          checked;
    bit          file_ok;

    copad_top i_copad_top (
        .clock               (clock),
        .arst_n              (arst_n),
        .a_vpf               (a_vpf),
        .a_roll              (a_roll),
        .a_pad               (a_pad),
        .a_cnt               (a_cnt),
        .b_vpf               (b_vpf),
        .b_roll              (b_roll),
        .b_pad               (b_pad),
        .b_cnt               (b_cnt),
        .match_neighbor_roll (match_neighbor_roll),
        .match_neighbor_pad  (match_neighbor_pad),
        .match_delta_pad     (match_delta_pad),
        .match               (match),
        .match_upper         (match_upper),
        .match_lower         (match_lower),
        .any_match           (any_match)
    );

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    // ------------------------------
    // stimulus
    // ------------------------------

    task automatic load_golden();
        int fd;
        fd = $fopen(golden_file, "r");
        if (fd == 0) begin
            file_ok = 1'b0;
            errors++;
            $display("could not open the golden vector file %s", golden_file);
        end else begin
            $fclose(fd);
            $readmemh(golden_file, golden);
            file_ok = 1'b1;
        end
    endtask

    task automatic apply_vector(input int idx);
        int          base;
        logic [27:0] cfg;
        logic [27:0] a_word;
        logic [27:0] b_word;
        base = idx * words_per_line;
        cfg  = golden[base];     // r_p_d
        match_neighbor_roll <= cfg[8];
        match_neighbor_pad  <= cfg[4];
        match_delta_pad     <= cfg[3:0];
        for (int i = 0; i < `COPAD_N_CLUSTERS; i++) begin
            a_word = golden[base + 1 + i];
            b_word = golden[base + 1 + `COPAD_N_CLUSTERS + i];
            a_vpf[i]  <= a_word[16];   // cluster word is v_r_pp_c
            a_roll[i] <= a_word[14:12];
            a_pad[i]  <= a_word[11:4];
            a_cnt[i]  <= a_word[2:0];
            b_vpf[i]  <= b_word[16];
            b_roll[i] <= b_word[14:12];
            b_pad[i]  <= b_word[11:4];
            b_cnt[i]  <= b_word[2:0];
        end
    endtask

    task automatic drive_vectors();
        for (int v = 0; v < n_vectors; v++) begin
            @(posedge clock);
            apply_vector(v);
            sent.push_back(v);
        end
        // empty crossings push the last vectors out of the pipeline
        forever begin
            @(posedge clock);
            a_vpf <= '0;
            b_vpf <= '0;
            sent.push_back(-1);
        end
    endtask

    // ------------------------------
    // checking
    // ------------------------------

    function automatic string test_name(input int idx);
        string group;
        if (idx < 4)       group = "exact_match";
        else if (idx < 9)  group = "pad_tolerance";
        else if (idx < 14) group = "neighbor_roll";
        else if (idx < 17) group = "valid_flags";
        else if (idx < 23) group = "back_to_back";
        else               group = "idle";
        return $sformatf("%s[%0d]", group, idx);
    endfunction

    // expected word is mm_uu_ll_a
    task automatic compare_outputs(input string name, input logic [27:0] exp);
        assert (match === exp[27:20]) else begin
            errors++;
            $display("** Error %s match: expected %h, actual %h", name, exp[27:20], match);
        end
        assert (match_upper === exp[19:12]) else begin
            errors++;
            $display("** Error %s match_upper: expected %h, actual %h",
                     name, exp[19:12], match_upper);
        end
        assert (match_lower === exp[11:4]) else begin
            errors++;
            $display("** Error %s match_lower: expected %h, actual %h",
                     name, exp[11:4], match_lower);
        end
        assert (any_match === exp[0]) else begin
            errors++;
            $display("** Error %s any_match: expected %b, actual %b", name, exp[0], any_match);
        end
    endtask

    initial begin
        int cycles;
        int idx;
        arst_n              = 1'b0;
        a_vpf               = '0;
        a_roll              = '0;
        a_pad               = '0;
        a_cnt               = '0;
        b_vpf               = '0;
        b_roll              = '0;
        b_pad               = '0;
        b_cnt               = '0;
        match_neighbor_roll = 1'b0;
        match_neighbor_pad  = 1'b0;
        match_delta_pad     = '0;
        errors              = 0;
        checked             = 0;
        cycles              = 0;
        load_golden();
        repeat (10) @(posedge clock);
        arst_n <= 1'b1;
        @(negedge clock);
        compare_outputs("reset", '0);   // nothing driven yet
        if (file_ok) begin
            fork
                drive_vectors();
            join_none
        end
        // a crossing reaches the outputs two edges after it is driven
        while (file_ok && checked < n_vectors) begin
            @(negedge clock);
            if (sent.size() > latency) begin
                idx = sent.pop_front();
                if (idx >= 0) begin
                    compare_outputs(test_name(idx), golden[idx * words_per_line + words_per_line - 1]);
                    checked++;
                end
            end
            cycles++;
            if (cycles > timeout_cycles) begin
                errors++;
                $display("timed out waiting for results, %0d of %0d vectors checked",
                         checked, n_vectors);
                break;
            end
        end
        $display("vectors checked: %0d of %0d, errors: %0d", checked, n_vectors, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule
